//--- build.f
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_alu.sv
verilog/exu_mul.sv
verilog/exu_stage_reg.sv
verilog/exu_execute.sv
sim/tb_exu.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f build.f \
    --top-module tb_exu \
    -o tb_exu

status=0
out=$(./obj_dir/tb_exu 2>&1) || status=$?
echo "$out"

if echo "$out" | grep -q "^Done: no errors$"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed (exit status $status)"
exit 1

//--- sim/tb_exu.sv
// Testbench for the execute stage
// Clock and reset, directed and random stimulus, reference model
// Compare process, back-pressure, flush scenarios and cycle timeout

`timescale 1ns/10ps

`include "exu_settings.svh"

module tb_exu;

    localparam int XL         = `EXU_XLEN;
    localparam int N_DIRECTED = 22 * 25;                    // Every opcode on edge pairs
    localparam int N_RANDOM   = 400;
    localparam int N_TOTAL    = N_DIRECTED + N_RANDOM + 8;  // Plus flush scenarios
    localparam int MAX_CYCLES = N_TOTAL * (`EXU_MUL_STEPS + 8) * 2;

    logic                   g_clk;
    logic                   g_resetn;
    logic                   i_flush;
    logic                   i_valid;
    exu_pkg::issue_t        i_issue;
    logic                   o_busy;
    logic                   o_valid;
    exu_pkg::result_t       o_result;
    logic                   i_busy = 1'b0;
    logic [`EXU_REG_AW-1:0] o_fwd_rd;
    logic [XL-1:0]          o_fwd_wdata;
    logic                   o_fwd_load;

    exu_pkg::result_t exp_q[$];                 // Expected results in issue order
    exu_pkg::result_t last_result;
    logic             last_hold   = 1'b0;       // Stalled result seen last sample
    logic             accept_next = 1'b0;       // Input taken on coming edge
    logic [1:0]       busy_mode   = 2'd0;       // 0 free, 1 random, 2 stuck
    int               cycle_count = 0;

    logic [XL-1:0] edge_vals [5] = '{32'h0, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF, 32'h1F};

    exu_pkg::uop_e op_list [22] = '{
        exu_pkg::ADD, exu_pkg::SUB, exu_pkg::XOR, exu_pkg::OR, exu_pkg::AND, exu_pkg::SLL,
        exu_pkg::SRL, exu_pkg::SRA, exu_pkg::SLT, exu_pkg::SLTU, exu_pkg::MUL, exu_pkg::MULH,
        exu_pkg::MULHU, exu_pkg::LOAD, exu_pkg::STORE, exu_pkg::BEQ, exu_pkg::BNE,
        exu_pkg::BLT, exu_pkg::BGE, exu_pkg::BLTU, exu_pkg::BGEU, exu_pkg::JALR
    };

    exu_execute dut0 (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_flush     (i_flush),
        .i_valid     (i_valid),
        .i_issue     (i_issue),
        .o_busy      (o_busy),
        .o_valid     (o_valid),
        .o_result    (o_result),
        .i_busy      (i_busy),
        .o_fwd_rd    (o_fwd_rd),
        .o_fwd_wdata (o_fwd_wdata),
        .o_fwd_load  (o_fwd_load)
    );

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;              // 8 ns period
    end

    // --------------------
    // Reference model
    // --------------------

    function automatic exu_pkg::result_t ref_result(input exu_pkg::issue_t ins);
        exu_pkg::result_t r;
        longint           sa;
        longint           sb;
        longint unsigned  ua;
        longint unsigned  ub;
        longint unsigned  prod;
        int unsigned      sh;
        logic             taken;
        sa    = longint'($signed(ins.opr_a));   // Sign extended
        sb    = longint'($signed(ins.opr_b));
        ua    = {32'b0, ins.opr_a};             // Zero extended
        ub    = {32'b0, ins.opr_b};
        sh    = ins.opr_b % XL;
        prod  = ua * ub;
        taken = 1'b0;
        r.rd  = ins.rd;
        r.fu  = ins.fu;
        r.uop = ins.uop;
        r.opr_a = '0;
        r.opr_b = '0;
        case (ins.uop)
            exu_pkg::ADD:   r.opr_a = XL'(ua + ub);
            exu_pkg::SUB:   r.opr_a = XL'(ua - ub);
            exu_pkg::XOR:   r.opr_a = ins.opr_a ^ ins.opr_b;
            exu_pkg::OR:    r.opr_a = ins.opr_a | ins.opr_b;
            exu_pkg::AND:   r.opr_a = ins.opr_a & ins.opr_b;
            exu_pkg::SLL:   r.opr_a = XL'(ua << sh);
            exu_pkg::SRL:   r.opr_a = XL'(ua >> sh);
            exu_pkg::SRA:   r.opr_a = XL'(sa >>> sh);
            exu_pkg::SLT:   r.opr_a = (sa < sb) ? 1 : 0;
            exu_pkg::SLTU:  r.opr_a = (ua < ub) ? 1 : 0;
            exu_pkg::MUL: begin
                r.opr_a = prod[XL-1:0];
                r.opr_b = prod[2*XL-1:XL];      // Unsigned high word
            end
            exu_pkg::MULH: begin
                prod    = longint'(sa * sb);
                r.opr_a = prod[2*XL-1:XL];
                r.opr_b = prod[2*XL-1:XL];
            end
            exu_pkg::MULHU: begin
                r.opr_a = prod[2*XL-1:XL];
                r.opr_b = prod[2*XL-1:XL];
            end
            exu_pkg::LOAD, exu_pkg::STORE: begin
                r.opr_a = XL'(ua + ub);         // Effective address
                r.opr_b = ins.opr_c;
            end
            exu_pkg::BEQ:   taken = (ua == ub);
            exu_pkg::BNE:   taken = (ua != ub);
            exu_pkg::BLT:   taken = (sa < sb);
            exu_pkg::BGE:   taken = (sa >= sb);
            exu_pkg::BLTU:  taken = (ua < ub);
            exu_pkg::BGEU:  taken = (ua >= ub);
            exu_pkg::JALR:  r.opr_a = XL'(ua + ub) & ~32'h1;
            default:        r.opr_a = '0;
        endcase
        if (ins.uop inside {[exu_pkg::BEQ:exu_pkg::BGEU]}) begin
            r.uop   = taken ? exu_pkg::TAKEN : exu_pkg::NOT_TAKEN;
            r.opr_a = ins.opr_c & ~32'h1;       // Target with bit 0 cleared
        end
        return r;
    endfunction

    // --------------------
    // Stimulus helpers
    // --------------------

    function automatic exu_pkg::issue_t make_instr(input exu_pkg::uop_e op,
            input logic [XL-1:0] a, input logic [XL-1:0] b, input logic [XL-1:0] c);
        exu_pkg::issue_t ins;
        ins.rd    = $urandom_range(0, (1 << `EXU_REG_AW) - 1);
        ins.uop   = op;
        ins.opr_a = a;
        ins.opr_b = b;
        ins.opr_c = c;
        if (op inside {exu_pkg::MUL, exu_pkg::MULH, exu_pkg::MULHU}) begin
            ins.fu = exu_pkg::FU_MUL;
        end else if (op inside {exu_pkg::LOAD, exu_pkg::STORE}) begin
            ins.fu = exu_pkg::FU_LSU;
        end else if (op inside {[exu_pkg::BEQ:exu_pkg::JALR]}) begin
            ins.fu = exu_pkg::FU_CFU;
        end else begin
            ins.fu = exu_pkg::FU_ALU;
        end
        return ins;
    endfunction

    function automatic logic [XL-1:0] rand_operand();
        int unsigned pick;
        pick = $urandom % 12;
        if (pick < 5) begin
            return edge_vals[pick];             // Edge value now and then
        end
        return $urandom;
    endfunction

    function automatic exu_pkg::issue_t rand_instr();
        logic [XL-1:0] a;
        logic [XL-1:0] b;
        a = rand_operand();
        b = ($urandom % 4 == 0) ? a : rand_operand();   // Equal pairs for beq/bne
        return make_instr(op_list[$urandom % 22], a, b, $urandom);
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
            input logic [127:0] want);
        if (got !== want) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
            $display("Done: errors found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic compare_result(input exu_pkg::result_t want);
        check_value("o_result.rd", o_result.rd, want.rd);
        check_value("o_result.fu", o_result.fu, want.fu);
        check_value("o_result.uop", o_result.uop, want.uop);
        check_value("o_result.opr_a", o_result.opr_a, want.opr_a);
        check_value("o_result.opr_b", o_result.opr_b, want.opr_b);
    endtask

    // Present and hold until the stage takes it
    task automatic send(input exu_pkg::issue_t ins);
        i_valid <= 1'b1;
        i_issue <= ins;
        do begin
            @(posedge g_clk);
        end while (!accept_next);
    endtask

    task automatic flush_stage();
        i_valid <= 1'b0;                        // Dropped instruction goes too
        i_flush <= 1'b1;
        @(posedge g_clk);
        i_flush <= 1'b0;
        @(negedge g_clk);
        check_value("o_valid after flush", o_valid, 1'b0);
        @(posedge g_clk);
    endtask

    task automatic drain();
        i_valid   <= 1'b0;
        busy_mode <= 2'd0;
        while (exp_q.size() != 0) begin
            @(posedge g_clk);
        end
    endtask

    // --------------------
    // Back-pressure and timeout
    // --------------------

    always @(posedge g_clk) begin
        case (busy_mode)
            2'd1:    i_busy <= ($urandom % 3 == 0);
            2'd2:    i_busy <= 1'b1;
            default: i_busy <= 1'b0;
        endcase
    end

    always @(posedge g_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $fatal(1, "simulation timed out");
        end
    end

    // --------------------
    // Compare process
    // --------------------

    // Samples at the falling edge between input updates
    always @(negedge g_clk) begin : monitor
        exu_pkg::result_t want;
        accept_next = 1'b0;
        if (g_resetn) begin
            if (last_hold) begin
                check_value("o_valid (held)", o_valid, 1'b1);
                check_value("o_result (held)", o_result, last_result);
            end
            if (i_flush) begin
                exp_q.delete();                 // Everything in flight is dropped
            end else begin
                if (o_valid && !i_busy) begin
                    if (exp_q.size() == 0) begin
                        $display("A result came out with no accepted instruction to match");
                        $display("Done: errors found");
                        $fatal(1, "unexpected result");
                    end else begin
                        compare_result(exp_q.pop_front());
                    end
                end
                if (i_valid) begin
                    want = ref_result(i_issue);
                    check_value("o_fwd_rd", o_fwd_rd, i_issue.rd);
                    check_value("o_fwd_load", o_fwd_load, i_issue.uop == exu_pkg::LOAD);
                    if (i_issue.fu != exu_pkg::FU_MUL) begin
                        check_value("o_fwd_wdata", o_fwd_wdata, want.opr_a);
                    end
                    if (!o_busy) begin
                        exp_q.push_back(want);
                        accept_next = 1'b1;
                    end
                end
            end
            last_hold   = o_valid && i_busy && !i_flush;
            last_result = o_result;
        end
    end

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        void'($urandom(24));
        g_resetn = 1'b0;
        i_flush  = 1'b0;
        i_valid  = 1'b0;
        i_issue  = '0;
        repeat (16) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        check_value("o_valid after reset", o_valid, 1'b0);
        check_value("o_busy after reset", o_busy, 1'b0);
        @(posedge g_clk);

        // Every opcode on edge operand pairs back to back
        for (int k = 0; k < 22; k++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    send(make_instr(op_list[k], edge_vals[i], edge_vals[j],
                                    edge_vals[(i + j) % 5] ^ 32'h3));
                end
            end
        end
        drain();

        // Random mix under random back-pressure
        busy_mode <= 2'd1;
        repeat (N_RANDOM) begin
            send(rand_instr());
        end
        drain();

        // Flush while a multiply runs
        send(make_instr(exu_pkg::ADD, 32'h5, 32'h7, 32'h0));
        i_valid <= 1'b1;
        i_issue <= make_instr(exu_pkg::MULH, 32'h8000_0000, 32'h7FFF_FFFF, 32'h0);
        repeat (6) @(posedge g_clk);
        flush_stage();
        send(make_instr(exu_pkg::MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0));
        drain();

        // Flush while a result waits on a stalled consumer
        busy_mode <= 2'd2;
        @(posedge g_clk);
        send(make_instr(exu_pkg::XOR, 32'hA5A5_A5A5, 32'h0F0F_0F0F, 32'h0));
        i_valid <= 1'b0;
        repeat (3) @(posedge g_clk);
        flush_stage();
        busy_mode <= 2'd0;
        send(make_instr(exu_pkg::SRA, 32'h8000_0000, 32'h1F, 32'h0));
        drain();

        if (exp_q.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("%0d expected results never came out", exp_q.size());
            $display("Done: errors found");
            $fatal(1, "results missing");
        end
    end

endmodule

//--- verilog/exu_alu.sv
// Combinational integer ALU
// Adder, subtractor, shifter, logic ops and a shared comparator
// The comparator also serves branch resolution in the stage top

`timescale 1ns/10ps

`include "exu_settings.svh"

module exu_alu (
    input  exu_pkg::uop_e        i_uop,         // Operation select
    input  logic [`EXU_XLEN-1:0] i_lhs,         // Left operand
    input  logic [`EXU_XLEN-1:0] i_rhs,         // Right operand
    output logic [`EXU_XLEN-1:0] o_result,      // Selected ALU result
    output logic [`EXU_XLEN-1:0] o_add_result,  // Plain sum for LSU/JALR
    output logic                 o_lt,          // LHS below RHS
    output logic                 o_eq           // LHS equals RHS
);

    localparam int XL  = `EXU_XLEN;
    localparam int SHW = $clog2(`EXU_XLEN);     // Shift amount bits

    logic [XL:0]    sub_wide;                   // Difference with borrow
    logic           lt_unsigned;
    logic           lt_signed;
    logic           cmp_unsigned;
    logic [SHW-1:0] shamt;
    logic [XL-1:0]  sll_res;
    logic [XL-1:0]  srl_res;
    logic [XL-1:0]  sra_res;

    // --------------------
    // Adder and comparator
    // --------------------

    assign o_add_result = i_lhs + i_rhs;                    // Address and jalr sum
    assign sub_wide     = {1'b0, i_lhs} - {1'b0, i_rhs};    // Borrow lands in MSB

    assign lt_unsigned = sub_wide[XL];                      // Borrow out
    // Differing signs decide directly, otherwise unsigned order holds
    assign lt_signed   = (i_lhs[XL-1] != i_rhs[XL-1]) ? i_lhs[XL-1] : lt_unsigned;

    assign cmp_unsigned = i_uop inside {exu_pkg::SLTU, exu_pkg::BLTU, exu_pkg::BGEU};

    assign o_lt = cmp_unsigned ? lt_unsigned : lt_signed;   // Shared by slt and branches
    assign o_eq = (i_lhs == i_rhs);

    // --------------------
    // Shifter
    // --------------------

    assign shamt   = i_rhs[SHW-1:0];                        // Low bits only
    assign sll_res = i_lhs << shamt;
    assign srl_res = i_lhs >> shamt;
    assign sra_res = $unsigned($signed(i_lhs) >>> shamt);   // Sign fill

    // --------------------
    // Result select
    // --------------------

    always_comb begin
        case (i_uop)
            exu_pkg::ADD: begin
                o_result = o_add_result;
            end
            exu_pkg::SUB: begin
                o_result = sub_wide[XL-1:0];                // Drop borrow
            end
            exu_pkg::XOR: begin
                o_result = i_lhs ^ i_rhs;
            end
            exu_pkg::OR: begin
                o_result = i_lhs | i_rhs;
            end
            exu_pkg::AND: begin
                o_result = i_lhs & i_rhs;
            end
            exu_pkg::SLL: begin
                o_result = sll_res;
            end
            exu_pkg::SRL: begin
                o_result = srl_res;
            end
            exu_pkg::SRA: begin
                o_result = sra_res;
            end
            exu_pkg::SLT, exu_pkg::SLTU: begin
                o_result = {{(XL-1){1'b0}}, o_lt};          // Zero or one
            end
            default: begin
                o_result = '0;                              // Non-ALU opcode
            end
        endcase
    end

endmodule

//--- verilog/exu_execute.sv
// Execute stage top
// Unit decode, branch resolution, result mux and stall logic
// Instantiates the ALU, the multiplier and the output register
// Forwarding outputs show the instruction currently at the input

`timescale 1ns/10ps

`include "exu_settings.svh"

module exu_execute (
    input  logic                   g_clk,       // Clock
    input  logic                   g_resetn,    // Sync reset, active low
    input  logic                   i_flush,     // Empty the stage
    input  logic                   i_valid,     // Issue valid
    input  exu_pkg::issue_t        i_issue,     // Decoded instruction
    output logic                   o_busy,      // Cannot accept this cycle
    output logic                   o_valid,     // Result valid
    output exu_pkg::result_t       o_result,    // Result to next stage
    input  logic                   i_busy,      // Next stage stalled
    output logic [`EXU_REG_AW-1:0] o_fwd_rd,    // Forwarded destination
    output logic [`EXU_XLEN-1:0]   o_fwd_wdata, // Forwarded write data
    output logic                   o_fwd_load   // Input holds a load
);

    localparam int XL = `EXU_XLEN;

    logic             is_mul;
    logic             is_lsu;
    logic             is_jalr;
    logic             p_valid;                  // Instruction accepted
    logic             reg_busy;
    logic             mul_start;
    logic             mul_abort;
    logic             mul_ready;
    logic [2*XL-1:0]  mul_product;
    logic [XL-1:0]    alu_result;
    logic [XL-1:0]    alu_add_result;
    logic             alu_lt;
    logic             alu_eq;
    logic             cond_taken;
    exu_pkg::result_t n_result;                 // Next register contents

    // --------------------
    // Decode and stall
    // --------------------

    assign is_mul  = (i_issue.fu == exu_pkg::FU_MUL);
    assign is_lsu  = (i_issue.fu == exu_pkg::FU_LSU);
    assign is_jalr = (i_issue.uop == exu_pkg::JALR);

    assign mul_start = i_valid && is_mul;                   // Level while mul waits
    assign o_busy    = reg_busy || (mul_start && !mul_ready);
    assign p_valid   = i_valid && !o_busy;
    assign mul_abort = p_valid || i_flush;                  // Release product

    // --------------------
    // Functional units
    // --------------------

    exu_alu u_alu (
        .i_uop        (i_issue.uop),
        .i_lhs        (i_issue.opr_a),
        .i_rhs        (i_issue.opr_b),
        .o_result     (alu_result),
        .o_add_result (alu_add_result),
        .o_lt         (alu_lt),
        .o_eq         (alu_eq)
    );

    exu_mul u_mul (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .i_start   (mul_start),
        .i_abort   (mul_abort),
        .i_uop     (i_issue.uop),
        .i_rs1     (i_issue.opr_a),
        .i_rs2     (i_issue.opr_b),
        .o_product (mul_product),
        .o_ready   (mul_ready)
    );

    // Branch condition from the shared comparator
    always_comb begin
        case (i_issue.uop)
            exu_pkg::BEQ:                begin cond_taken = alu_eq;  end
            exu_pkg::BNE:                begin cond_taken = !alu_eq; end
            exu_pkg::BLT, exu_pkg::BLTU: begin cond_taken = alu_lt;  end
            exu_pkg::BGE, exu_pkg::BGEU: begin cond_taken = !alu_lt; end
            default:                     begin cond_taken = 1'b0;    end
        endcase
    end

    // --------------------
    // Result mux
    // --------------------

    always_comb begin
        n_result.rd    = i_issue.rd;
        n_result.fu    = i_issue.fu;
        n_result.uop   = i_issue.uop;
        n_result.opr_a = alu_result;
        n_result.opr_b = '0;
        case (i_issue.fu)
            exu_pkg::FU_ALU: begin
                n_result.opr_a = alu_result;
            end
            exu_pkg::FU_MUL: begin
                // Low word only for MUL
                n_result.opr_a = (i_issue.uop == exu_pkg::MUL) ? mul_product[XL-1:0]
                                                               : mul_product[2*XL-1:XL];
                n_result.opr_b = mul_product[2*XL-1:XL];    // High word always
            end
            exu_pkg::FU_LSU: begin
                n_result.opr_a = alu_add_result;            // Effective address
                n_result.opr_b = i_issue.opr_c;             // Store data
            end
            exu_pkg::FU_CFU: begin
                if (is_jalr) begin
                    n_result.opr_a = {alu_add_result[XL-1:1], 1'b0};
                end else begin
                    n_result.uop   = cond_taken ? exu_pkg::TAKEN : exu_pkg::NOT_TAKEN;
                    n_result.opr_a = {i_issue.opr_c[XL-1:1], 1'b0};
                end
            end
        endcase
    end

    exu_stage_reg u_stage_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_flush  (i_flush),
        .i_load   (p_valid),
        .i_data   (n_result),
        .i_busy   (i_busy),
        .o_busy   (reg_busy),
        .o_valid  (o_valid),
        .o_data   (o_result)
    );

    // --------------------
    // Forwarding
    // --------------------

    assign o_fwd_rd    = i_issue.rd;
    assign o_fwd_wdata = n_result.opr_a;                    // Same value as writeback
    assign o_fwd_load  = is_lsu && (i_issue.uop == exu_pkg::LOAD);

endmodule

//--- verilog/exu_mul.sv
// Iterative shift-add multiplier for mul, mulh and mulhu
// Works on magnitudes and fixes the sign after the last step
// Product and ready hold until the stage aborts the operation

`timescale 1ns/10ps

`include "exu_settings.svh"

module exu_mul (
    input  logic                   g_clk,       // Clock
    input  logic                   g_resetn,    // Sync reset, active low
    input  logic                   i_start,     // Multiply waiting at input
    input  logic                   i_abort,     // Accepted or flushed
    input  exu_pkg::uop_e          i_uop,       // MUL, MULH or MULHU
    input  logic [`EXU_XLEN-1:0]   i_rs1,       // Multiplicand
    input  logic [`EXU_XLEN-1:0]   i_rs2,       // Multiplier
    output logic [2*`EXU_XLEN-1:0] o_product,   // Full width product
    output logic                   o_ready      // Product valid
);

    localparam int XL = `EXU_XLEN;
    localparam int CW = $clog2(`EXU_MUL_STEPS); // Step counter width

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } state_e;

    state_e          r_state;
    logic [CW-1:0]   r_count;                   // Steps done so far
    logic [XL-1:0]   r_mcand;                   // Multiplicand magnitude
    logic [2*XL-1:0] r_prod;                    // Partial product over multiplier
    logic            r_neg;                     // Negate at the end

    logic            signed_op;
    logic            a_neg;
    logic            b_neg;
    logic [XL-1:0]   a_mag;
    logic [XL-1:0]   b_mag;
    logic [XL:0]     step_sum;
    logic [2*XL-1:0] step_prod;
    logic            last_step;

    // Only MULH reads the operands as signed
    assign signed_op = (i_uop == exu_pkg::MULH);
    assign a_neg     = signed_op && i_rs1[XL-1];
    assign b_neg     = signed_op && i_rs2[XL-1];
    assign a_mag     = a_neg ? (~i_rs1 + 1'b1) : i_rs1;
    assign b_mag     = b_neg ? (~i_rs2 + 1'b1) : i_rs2;

    // One step: add on LSB, then shift everything right
    assign step_sum  = {1'b0, r_prod[2*XL-1:XL]} + (r_prod[0] ? {1'b0, r_mcand} : '0);
    assign step_prod = {step_sum, r_prod[XL-1:1]};
    assign last_step = (r_count == CW'(`EXU_MUL_STEPS - 1));

    // --------------------
    // Control FSM
    // --------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_abort) begin
            r_state <= IDLE;                    // Abort wins over start
            r_count <= '0;
        end else begin
            case (r_state)
                IDLE: begin
                    if (i_start) begin
                        r_state <= RUN;
                    end
                    r_count <= '0;
                end
                RUN: begin
                    r_count <= r_count + 1'b1;
                    if (last_step) begin
                        r_state <= DONE;
                    end
                end
                default: begin
                    r_count <= '0;              // DONE holds for abort
                end
            endcase
        end
    end

    // --------------------
    // Data path
    // --------------------

    always_ff @(posedge g_clk) begin
        if (r_state == IDLE && i_start) begin
            r_mcand <= a_mag;                   // Latch operands
            r_prod  <= {{XL{1'b0}}, b_mag};
            r_neg   <= a_neg ^ b_neg;
        end else if (r_state == RUN) begin
            if (last_step && r_neg) begin
                r_prod <= ~step_prod + 1'b1;    // Sign fix-up
            end else begin
                r_prod <= step_prod;
            end
        end
    end

    assign o_product = r_prod;
    assign o_ready   = (r_state == DONE);

endmodule

//--- verilog/exu_pkg.sv
// Shared types for the execute stage
// Functional unit enum, opcode enum, issue and result structs

`include "exu_settings.svh"

package exu_pkg;

    // --------------------
    // Functional units
    // --------------------

    typedef enum logic [1:0] {
        FU_ALU = 2'd0,              // Integer ALU
        FU_MUL = 2'd1,              // Iterative multiplier
        FU_LSU = 2'd2,              // Load/store address gen
        FU_CFU = 2'd3               // Branch and jump resolution
    } fu_e;

    // --------------------
    // Opcodes
    // --------------------

    typedef enum logic [4:0] {
        ADD       = 5'd0,           // ALU group
        SUB       = 5'd1,
        XOR       = 5'd2,
        OR        = 5'd3,
        AND       = 5'd4,
        SLL       = 5'd5,
        SRL       = 5'd6,
        SRA       = 5'd7,
        SLT       = 5'd8,
        SLTU      = 5'd9,
        MUL       = 5'd10,          // Multiplier group
        MULH      = 5'd11,
        MULHU     = 5'd12,
        LOAD      = 5'd13,          // Load/store group
        STORE     = 5'd14,
        BEQ       = 5'd16,          // Conditional branches
        BNE       = 5'd17,
        BLT       = 5'd18,
        BGE       = 5'd19,
        BLTU      = 5'd20,
        BGEU      = 5'd21,
        JALR      = 5'd22,          // Indirect jump
        TAKEN     = 5'd24,          // Resolved branch outcomes
        NOT_TAKEN = 5'd25
    } uop_e;

    // Decoded instruction entering the stage
    typedef struct packed {
        logic [`EXU_REG_AW-1:0] rd;     // Destination register
        fu_e                    fu;     // Target unit
        uop_e                   uop;    // Operation
        logic [`EXU_XLEN-1:0]   opr_a;  // Operand A
        logic [`EXU_XLEN-1:0]   opr_b;  // Operand B
        logic [`EXU_XLEN-1:0]   opr_c;  // Store data or branch target
    } issue_t;

    // Result handed to the next stage
    typedef struct packed {
        logic [`EXU_REG_AW-1:0] rd;     // Destination register
        fu_e                    fu;     // Unit that produced it
        uop_e                   uop;    // Opcode or branch outcome
        logic [`EXU_XLEN-1:0]   opr_a;  // Main result
        logic [`EXU_XLEN-1:0]   opr_b;  // Secondary result
    } result_t;

endpackage

//--- verilog/exu_settings.svh
// Global sizing for the execute stage
// Data width, register address width and multiplier step count

`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// --------------------
// Data path
// --------------------

`define EXU_XLEN      32    // Operand and result width
`define EXU_REG_AW    5     // Register file address width

// --------------------
// Multiplier
// --------------------

// One add-shift step per bit of the multiplier operand,
// so this tracks the data width
`define EXU_MUL_STEPS 32    // Add-shift iterations per multiply

`endif

//--- verilog/exu_stage_reg.sv
// Output pipeline register of the execute stage
// Holds one result with valid/busy handshake and flush

`timescale 1ns/10ps

`include "exu_settings.svh"

module exu_stage_reg (
    input  logic             g_clk,     // Clock
    input  logic             g_resetn,  // Sync reset, active low
    input  logic             i_flush,   // Drop held result
    input  logic             i_load,    // New result from stage top
    input  exu_pkg::result_t i_data,    // Result to capture
    input  logic             i_busy,    // Downstream stalled
    output logic             o_busy,    // Full and blocked
    output logic             o_valid,   // Result on offer
    output exu_pkg::result_t o_data     // Held result
);

    logic             r_valid;
    exu_pkg::result_t r_data;
    logic             load_en;

    assign o_busy  = r_valid && i_busy;         // Stall only when full
    assign load_en = i_load && !o_busy;

    // Valid bit
    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            r_valid <= 1'b0;
        end else if (load_en) begin
            r_valid <= 1'b1;                    // Refill, possibly as old one leaves
        end else if (!i_busy) begin
            r_valid <= 1'b0;                    // Consumed
        end
    end

    // Payload, frozen under back-pressure
    always_ff @(posedge g_clk) begin
        if (load_en) begin
            r_data <= i_data;
        end
    end

    assign o_valid = r_valid;
    assign o_data  = r_data;

endmodule
